//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int reg_count  = 32;

  localparam logic [xlen-1:0] reset_pc = '0;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // Major opcodes of the kept instructions
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111
  } opcode_e;

  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;
  localparam logic [2:0] f3_beq     = 3'b000;
  localparam logic [2:0] f3_bne     = 3'b001;
  localparam logic [2:0] f3_word    = 3'b010; // Only word loads and stores

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000; // SUB and SRA

  // Register and immediate forms share one operation each
  typedef enum logic [3:0] {
    alu_nop,
    alu_lui,
    alu_add,
    alu_sub,
    alu_slt,
    alu_xor,
    alu_or,
    alu_and,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_lw,
    alu_sw,
    alu_beq,
    alu_bne,
    alu_jal
  } alu_op_e;

endpackage

//--- hw/rv_pipe_pkg.sv
package rv_pipe_pkg;

  // Fetch to decode
  typedef struct packed {
    logic              valid;
    rv_isa_pkg::word_t pc;
    rv_isa_pkg::word_t insn;
  } fetch_bundle_t;

  // Decode to execute, operands already read
  typedef struct packed {
    logic                  valid;
    rv_isa_pkg::alu_op_e   op;
    rv_isa_pkg::reg_addr_t rd;
    rv_isa_pkg::word_t     rs1_data;
    rv_isa_pkg::word_t     rs2_data; // Holds the immediate for OP-IMM
    rv_isa_pkg::word_t     imm;
    rv_isa_pkg::word_t     pc;
  } decode_bundle_t;

  typedef struct packed {
    logic                  en;
    rv_isa_pkg::reg_addr_t addr;
    rv_isa_pkg::word_t     data;
  } rf_write_t;

  typedef struct packed {
    logic              taken;
    rv_isa_pkg::word_t target;
  } redirect_t;

endpackage

//--- hw/rv_fetch.sv
`timescale 1ns/10ps

module rv_fetch (
  input  logic                       clk,
  input  logic                       i_arst_n,
  input  rv_pipe_pkg::redirect_t     i_redirect,
  input  logic                       i_stall,
  output rv_pipe_pkg::fetch_bundle_t o_fetch,
  output logic                       o_instbus_req,
  output rv_isa_pkg::word_t          o_instbus_addr,
  input  logic                       i_instbus_ack,
  input  rv_isa_pkg::word_t          i_instbus_data
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  typedef enum logic {
    st_fetch,
    st_discard
  } fetch_state_e;

  fetch_state_e  state_q;
  logic          req_q;
  word_t         addr_q;
  word_t         target_q;
  fetch_bundle_t fetch_q;
  logic          ack;
  logic          consume;

  assign ack     = req_q & i_instbus_ack;
  assign consume = ~i_stall; // Decode takes the bundle at this edge

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q  <= st_fetch;
      req_q    <= 1'b0;
      addr_q   <= reset_pc;
      target_q <= reset_pc;
      fetch_q  <= '0;
    end else if (i_redirect.taken) begin
      fetch_q.valid <= 1'b0;
      if (req_q && !ack) begin
        // The word in flight is from the old path and must still be taken off the bus
        state_q  <= st_discard;
        target_q <= i_redirect.target;
      end else begin
        state_q <= st_fetch;
        req_q   <= 1'b1;
        addr_q  <= i_redirect.target;
      end
    end else if (state_q == st_discard) begin
      if (ack) begin
        state_q <= st_fetch;
        addr_q  <= target_q; // Request stays up, now at the target
      end
    end else begin
      if (consume) begin
        fetch_q.valid <= 1'b0;
      end
      if (ack) begin
        if (!fetch_q.valid || consume) begin
          fetch_q <= '{valid: 1'b1, pc: addr_q, insn: i_instbus_data};
          addr_q  <= addr_q + 32'd4;
          req_q   <= consume;
        end else begin
          req_q <= 1'b0; // No room for the word, the same address is fetched again
        end
      end else if (!req_q && (!fetch_q.valid || consume)) begin
        req_q <= 1'b1;
      end
    end
  end

  assign o_fetch        = fetch_q;
  assign o_instbus_req  = req_q;
  assign o_instbus_addr = addr_q;

endmodule

//--- hw/rv_decode.sv
`timescale 1ns/10ps

module rv_decode (
  input  logic                        clk,
  input  logic                        i_arst_n,
  input  rv_pipe_pkg::fetch_bundle_t  i_fetch,
  input  rv_pipe_pkg::redirect_t      i_redirect,
  input  logic                        i_stall,
  output rv_isa_pkg::reg_addr_t       o_rs1_addr,
  output rv_isa_pkg::reg_addr_t       o_rs2_addr,
  input  rv_isa_pkg::word_t           i_rs1_data,
  input  rv_isa_pkg::word_t           i_rs2_data,
  output rv_pipe_pkg::decode_bundle_t o_decode
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  word_t          insn;
  opcode_e        opcode;
  logic [2:0]     funct3;
  logic [6:0]     funct7;
  word_t          imm_i;
  word_t          imm_s;
  word_t          imm_b;
  word_t          imm_u;
  word_t          imm_j;
  alu_op_e        op;
  word_t          imm;
  logic           use_imm;
  decode_bundle_t decode_q;

  assign insn   = i_fetch.insn;
  assign opcode = opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  assign o_rs1_addr = insn[19:15];
  assign o_rs2_addr = insn[24:20];

  always_comb begin
    op      = alu_nop;
    imm     = imm_i;
    use_imm = 1'b0;
    case (opcode)
      opc_lui: begin
        op  = alu_lui;
        imm = imm_u;
      end
      opc_op_imm: begin
        use_imm = 1'b1;
        case (funct3)
          f3_add_sub: op = alu_add;
          f3_slt:     op = alu_slt;
          f3_xor:     op = alu_xor;
          f3_or:      op = alu_or;
          f3_and:     op = alu_and;
          default:    op = alu_nop; // Immediate shifts are not supported
        endcase
      end
      opc_op: begin
        if (funct7 == f7_base) begin
          case (funct3)
            f3_add_sub: op = alu_add;
            f3_sll:     op = alu_sll;
            f3_slt:     op = alu_slt;
            f3_xor:     op = alu_xor;
            f3_srl_sra: op = alu_srl;
            f3_or:      op = alu_or;
            f3_and:     op = alu_and;
            default:    op = alu_nop;
          endcase
        end else if (funct7 == f7_alt) begin
          case (funct3)
            f3_add_sub: op = alu_sub;
            f3_srl_sra: op = alu_sra;
            default:    op = alu_nop;
          endcase
        end
      end
      opc_load: begin
        op = (funct3 == f3_word) ? alu_lw : alu_nop;
      end
      opc_store: begin
        op  = (funct3 == f3_word) ? alu_sw : alu_nop;
        imm = imm_s;
      end
      opc_branch: begin
        imm = imm_b;
        if (funct3 == f3_beq) begin
          op = alu_beq;
        end else if (funct3 == f3_bne) begin
          op = alu_bne;
        end
      end
      opc_jal: begin
        op  = alu_jal;
        imm = imm_j;
      end
      default: op = alu_nop;
    endcase
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      decode_q <= '0;
    end else if (i_redirect.taken) begin
      decode_q.valid <= 1'b0; // Wrong-path instruction
    end else if (!i_stall) begin
      decode_q <= '{valid:    i_fetch.valid,
                    op:       op,
                    rd:       insn[11:7],
                    rs1_data: i_rs1_data,
                    rs2_data: use_imm ? imm : i_rs2_data,
                    imm:      imm,
                    pc:       i_fetch.pc};
    end
  end

  assign o_decode = decode_q;

endmodule

//--- hw/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
  input  logic                   clk,
  input  logic                   i_arst_n,
  input  rv_pipe_pkg::rf_write_t i_write,
  input  rv_isa_pkg::reg_addr_t  i_rs1_addr,
  input  rv_isa_pkg::reg_addr_t  i_rs2_addr,
  output rv_isa_pkg::word_t      o_rs1_data,
  output rv_isa_pkg::word_t      o_rs2_data
);
  import rv_isa_pkg::*;

  word_t regs_q [1:reg_count-1];

  // A write in the same cycle wins over the stored value
  function automatic word_t read_port(reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end else if (i_write.en && i_write.addr == addr) begin
      return i_write.data;
    end
    return regs_q[addr];
  endfunction

  always_comb begin
    o_rs1_data = read_port(i_rs1_addr);
    o_rs2_data = read_port(i_rs2_addr);
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 1; i < reg_count; i++) begin
        regs_q[i] <= '0;
      end
    end else if (i_write.en && i_write.addr != '0) begin
      regs_q[i_write.addr] <= i_write.data;
    end
  end

endmodule

//--- hw/rv_execute.sv
`timescale 1ns/10ps

module rv_execute (
  input  logic                        clk,
  input  logic                        i_arst_n,
  input  rv_pipe_pkg::decode_bundle_t i_decode,
  output rv_pipe_pkg::rf_write_t      o_write,
  output rv_pipe_pkg::redirect_t      o_redirect,
  output logic                        o_stall,
  output logic                        o_membus_req,
  output logic                        o_membus_write,
  output rv_isa_pkg::word_t           o_membus_addr,
  output rv_isa_pkg::word_t           o_membus_data,
  input  logic                        i_membus_ack,
  input  rv_isa_pkg::word_t           i_membus_data
);
  import rv_isa_pkg::*;

  typedef enum logic {
    st_idle,
    st_wait
  } mem_state_e;

  mem_state_e state_q;
  logic       req_q;
  logic       write_q;
  word_t      addr_q;
  word_t      data_q;
  word_t      a;
  word_t      b;
  word_t      result;
  logic       writes_rd;
  logic       taken;
  logic       is_mem;
  logic       load_done;

  assign a = i_decode.rs1_data;
  assign b = i_decode.rs2_data;

  always_comb begin
    result    = '0;
    writes_rd = 1'b1;
    case (i_decode.op)
      alu_lui: result = i_decode.imm;
      alu_add: result = a + b;
      alu_sub: result = a - b;
      alu_slt: result = {31'b0, $signed(a) < $signed(b)};
      alu_xor: result = a ^ b;
      alu_or:  result = a | b;
      alu_and: result = a & b;
      alu_sll: result = a << b[4:0];
      alu_srl: result = a >> b[4:0];
      alu_sra: result = $signed(a) >>> b[4:0];
      alu_jal: result = i_decode.pc + 32'd4; // Link address
      default: writes_rd = 1'b0;
    endcase
  end

  always_comb begin
    case (i_decode.op)
      alu_beq: taken = (a == b);
      alu_bne: taken = (a != b);
      alu_jal: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  assign o_redirect = '{taken: i_decode.valid & taken, target: i_decode.pc + i_decode.imm};

  assign is_mem = i_decode.valid && (i_decode.op == alu_lw || i_decode.op == alu_sw);

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= st_idle;
      req_q   <= 1'b0;
      write_q <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (is_mem) begin
            state_q <= st_wait;
            req_q   <= 1'b1;
            write_q <= (i_decode.op == alu_sw);
          end
        end
        st_wait: begin
          if (i_membus_ack) begin
            state_q <= st_idle;
            req_q   <= 1'b0;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // Address and store data are held until the ack
  always_ff @(posedge clk) begin
    if (state_q == st_idle && is_mem) begin
      addr_q <= a + i_decode.imm;
      data_q <= b;
    end
  end

  // The memory op stays in this stage until its ack
  assign o_stall   = (state_q == st_idle) ? is_mem : ~i_membus_ack;
  assign load_done = (state_q == st_wait) && i_membus_ack && !write_q;

  assign o_write = '{en:   (i_decode.valid && writes_rd) || load_done,
                     addr: i_decode.rd,
                     data: load_done ? i_membus_data : result};

  assign o_membus_req   = req_q;
  assign o_membus_write = write_q;
  assign o_membus_addr  = addr_q;
  assign o_membus_data  = data_q;

endmodule

//--- hw/rv_core.sv
`timescale 1ns/10ps

module rv_core (
  input  logic              clk,
  input  logic              i_arst_n,

  output logic              o_instbus_req,
  output rv_isa_pkg::word_t o_instbus_addr,
  input  logic              i_instbus_ack,
  input  rv_isa_pkg::word_t i_instbus_data,

  output logic              o_membus_req,
  output logic              o_membus_write,
  output rv_isa_pkg::word_t o_membus_addr,
  output rv_isa_pkg::word_t o_membus_data,
  input  logic              i_membus_ack,
  input  rv_isa_pkg::word_t i_membus_data
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  fetch_bundle_t  fetch;
  decode_bundle_t decode;
  rf_write_t      rf_write;
  redirect_t      redirect;
  logic           stall;
  reg_addr_t      rs1_addr;
  reg_addr_t      rs2_addr;
  word_t          rs1_data;
  word_t          rs2_data;

  rv_fetch u_fetch (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_redirect     (redirect),
    .i_stall        (stall),
    .o_fetch        (fetch),
    .o_instbus_req  (o_instbus_req),
    .o_instbus_addr (o_instbus_addr),
    .i_instbus_ack  (i_instbus_ack),
    .i_instbus_data (i_instbus_data)
  );

  rv_decode u_decode (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_fetch    (fetch),
    .i_redirect (redirect),
    .i_stall    (stall),
    .o_rs1_addr (rs1_addr),
    .o_rs2_addr (rs2_addr),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_decode   (decode)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_write    (rf_write),
    .i_rs1_addr (rs1_addr),
    .i_rs2_addr (rs2_addr),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  rv_execute u_execute (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_decode       (decode),
    .o_write        (rf_write),
    .o_redirect     (redirect),
    .o_stall        (stall),
    .o_membus_req   (o_membus_req),
    .o_membus_write (o_membus_write),
    .o_membus_addr  (o_membus_addr),
    .o_membus_data  (o_membus_data),
    .i_membus_ack   (i_membus_ack),
    .i_membus_data  (i_membus_data)
  );

endmodule

//--- testbench/rv_core_assert.sv
`timescale 1ns/10ps

module rv_core_assert (
  input logic                  clk,
  input logic                  i_arst_n,
  input logic                  i_inst_req,
  input rv_isa_pkg::word_t     i_inst_addr,
  input logic                  i_inst_ack,
  input logic                  i_mem_req,
  input logic                  i_mem_write,
  input rv_isa_pkg::word_t     i_mem_addr,
  input rv_isa_pkg::word_t     i_mem_wdata,
  input logic                  i_mem_ack,
  input rv_isa_pkg::reg_addr_t i_rs1_addr,
  input rv_isa_pkg::word_t     i_rs1_data,
  input rv_isa_pkg::reg_addr_t i_rs2_addr,
  input rv_isa_pkg::word_t     i_rs2_data
);
  import rv_isa_pkg::*;

  logic seen_req_q; // Set once the first fetch request has gone out

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      seen_req_q <= 1'b0;
    end else if (i_inst_req) begin
      seen_req_q <= 1'b1;
    end
  end

  reset_quiet: assert property (@(posedge clk) !i_arst_n |-> (!i_inst_req && !i_mem_req))
    else begin
      $error("A bus request is high while reset is held");
      tb_rv_core.assert_errors = tb_rv_core.assert_errors + 1;
    end

  first_fetch: assert property (@(posedge clk) disable iff (!i_arst_n)
    (i_inst_req && !seen_req_q) |-> (i_inst_addr == reset_pc))
    else begin
      $error("The first instruction request is not at the reset address");
      tb_rv_core.assert_errors = tb_rv_core.assert_errors + 1;
    end

  // Request and its qualifiers hold until the ack
  inst_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
    (i_inst_req && !i_inst_ack) |=> (i_inst_req && $stable(i_inst_addr)))
    else begin
      $error("Instruction bus request changed before its ack");
      tb_rv_core.assert_errors = tb_rv_core.assert_errors + 1;
    end

  mem_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
    (i_mem_req && !i_mem_ack) |=> (i_mem_req && $stable(i_mem_write) &&
                                   $stable(i_mem_addr) && $stable(i_mem_wdata)))
    else begin
      $error("Memory bus request changed before its ack");
      tb_rv_core.assert_errors = tb_rv_core.assert_errors + 1;
    end

  x0_port1: assert property (@(posedge clk) disable iff (!i_arst_n)
    (i_rs1_addr == '0) |-> (i_rs1_data == '0))
    else begin
      $error("Register x0 reads nonzero on the first port");
      tb_rv_core.assert_errors = tb_rv_core.assert_errors + 1;
    end

  x0_port2: assert property (@(posedge clk) disable iff (!i_arst_n)
    (i_rs2_addr == '0) |-> (i_rs2_data == '0))
    else begin
      $error("Register x0 reads nonzero on the second port");
      tb_rv_core.assert_errors = tb_rv_core.assert_errors + 1;
    end

endmodule

//--- testbench/tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;
  import rv_isa_pkg::*;

  localparam int mem_words      = 64;
  localparam int timeout_cycles = 4000;

  logic  clk = 1'b0;
  logic  i_arst_n;
  logic  o_instbus_req;
  word_t o_instbus_addr;
  logic  i_instbus_ack;
  word_t i_instbus_data;
  logic  o_membus_req;
  logic  o_membus_write;
  word_t o_membus_addr;
  word_t o_membus_data;
  logic  i_membus_ack;
  word_t i_membus_data;

  word_t       imem [mem_words];
  word_t       dmem [mem_words];
  word_t       exp_addr [$]; // Stores made by the reference model, in order
  word_t       exp_data [$];
  int          prog_len;
  word_t       halt_pc;
  logic [31:0] seed;
  logic        ibus_busy;
  logic        dbus_busy;
  int          ibus_wait;
  int          dbus_wait;
  int          halt_hits;
  int          hits_start;
  int          cycles;
  int          mismatches;
  int          other_errors;
  int          assert_errors;
  int          stores_checked;

  rv_core dut (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .o_instbus_req  (o_instbus_req),
    .o_instbus_addr (o_instbus_addr),
    .i_instbus_ack  (i_instbus_ack),
    .i_instbus_data (i_instbus_data),
    .o_membus_req   (o_membus_req),
    .o_membus_write (o_membus_write),
    .o_membus_addr  (o_membus_addr),
    .o_membus_data  (o_membus_data),
    .i_membus_ack   (i_membus_ack),
    .i_membus_data  (i_membus_data)
  );

  bind rv_core rv_core_assert u_assert (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_inst_req  (o_instbus_req),
    .i_inst_addr (o_instbus_addr),
    .i_inst_ack  (i_instbus_ack),
    .i_mem_req   (o_membus_req),
    .i_mem_write (o_membus_write),
    .i_mem_addr  (o_membus_addr),
    .i_mem_wdata (o_membus_data),
    .i_mem_ack   (i_membus_ack),
    .i_rs1_addr  (rs1_addr),
    .i_rs1_data  (rs1_data),
    .i_rs2_addr  (rs2_addr),
    .i_rs2_data  (rs2_data)
  );

  always #20 clk = ~clk;

  function automatic word_t random_bits();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return {8'h00, seed[31:8]};
  endfunction

  function automatic word_t fill_word(int idx);
    return 32'hc3a5_0000 ^ (32'(idx) * 32'h0001_0203);
  endfunction

  function automatic word_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic word_t i_type(opcode_e opc, reg_addr_t rd, reg_addr_t rs1,
                                   logic [2:0] f3, logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t s_type(reg_addr_t rs2, reg_addr_t rs1, logic [11:0] off);
    return {off[11:5], rs2, rs1, f3_word, off[4:0], opc_store};
  endfunction

  function automatic word_t b_type(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2,
                                   logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
  endfunction

  function automatic word_t u_type(reg_addr_t rd, logic [19:0] imm);
    return {imm, rd, opc_lui};
  endfunction

  function automatic word_t j_type(reg_addr_t rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
  endfunction

  // Integer result by funct3 as the ISA defines it
  function automatic word_t alu_result(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      f3_add_sub: return alt ? a - b : a + b;
      f3_sll:     return a << b[4:0];
      f3_slt:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      f3_xor:     return a ^ b;
      f3_srl_sra: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      f3_or:      return a | b;
      default:    return a & b;
    endcase
  endfunction

  task automatic emit(word_t insn);
    imem[prog_len] = insn;
    prog_len++;
  endtask

  task automatic build_program();
    for (int i = 0; i < mem_words; i++) begin
      imem[i] = i_type(opc_op_imm, 5'd0, 5'd0, f3_add_sub, 12'(i * 4)); // No-op filler
      dmem[i] = fill_word(i);
    end
    prog_len = 0;
    emit(i_type(opc_op_imm, 5'd1, 5'd0, f3_add_sub, 12'd64)); // Data base pointer
    emit(i_type(opc_op_imm, 5'd2, 5'd0, f3_add_sub, 12'(random_bits())));
    emit(i_type(opc_op_imm, 5'd3, 5'd0, f3_add_sub, 12'(random_bits())));
    emit(u_type(5'd4, 20'(random_bits())));
    emit(i_type(opc_op_imm, 5'd5, 5'd2, f3_xor, 12'(random_bits())));
    emit(i_type(opc_op_imm, 5'd6, 5'd3, f3_or, 12'(random_bits())));
    emit(i_type(opc_op_imm, 5'd7, 5'd2, f3_and, 12'(random_bits())));
    emit(i_type(opc_op_imm, 5'd8, 5'd2, f3_slt, 12'(random_bits())));
    emit(r_type(f7_base, 5'd3, 5'd2, f3_add_sub, 5'd9));
    emit(r_type(f7_alt, 5'd3, 5'd2, f3_add_sub, 5'd10));
    emit(r_type(f7_base, 5'd2, 5'd3, f3_slt, 5'd11));
    emit(r_type(f7_base, 5'd2, 5'd4, f3_xor, 5'd12));
    emit(r_type(f7_base, 5'd3, 5'd4, f3_or, 5'd13));
    emit(r_type(f7_base, 5'd3, 5'd2, f3_and, 5'd14));
    emit(r_type(f7_base, 5'd3, 5'd4, f3_sll, 5'd15));
    emit(r_type(f7_base, 5'd2, 5'd4, f3_srl_sra, 5'd16));
    emit(r_type(f7_alt, 5'd3, 5'd4, f3_srl_sra, 5'd17));
    for (int r = 4; r <= 17; r++) begin
      emit(s_type(reg_addr_t'(r), 5'd1, 12'((r - 4) * 4)));
    end
    emit(i_type(opc_load, 5'd18, 5'd1, f3_word, 12'd128)); // Untouched fill word
    emit(r_type(f7_base, 5'd2, 5'd18, f3_add_sub, 5'd19));
    emit(s_type(5'd19, 5'd1, 12'd56));
    emit(i_type(opc_load, 5'd20, 5'd1, f3_word, 12'd0)); // Reads back the first store
    emit(s_type(5'd20, 5'd1, 12'd60));
    emit(i_type(opc_op_imm, 5'd0, 5'd2, f3_add_sub, 12'd5));
    emit(r_type(f7_base, 5'd3, 5'd2, f3_add_sub, 5'd0));
    emit(s_type(5'd0, 5'd1, 12'd64));
    emit(b_type(f3_beq, 5'd2, 5'd2, 13'd8)); // Taken
    emit(s_type(5'd2, 5'd1, 12'd68));
    emit(b_type(f3_bne, 5'd2, 5'd2, 13'd8)); // Falls through
    emit(s_type(5'd3, 5'd1, 12'd68));
    emit(b_type(f3_bne, 5'd1, 5'd0, 13'd8));
    emit(s_type(5'd2, 5'd1, 12'd72));
    emit(b_type(f3_beq, 5'd1, 5'd0, 13'd8));
    emit(s_type(5'd3, 5'd1, 12'd72));
    emit(j_type(5'd21, 21'd12)); // Skips two stores
    emit(s_type(5'd2, 5'd1, 12'd76));
    emit(s_type(5'd2, 5'd1, 12'd80));
    emit(s_type(5'd21, 5'd1, 12'd76));
    halt_pc = word_t'(prog_len * 4);
    emit(j_type(5'd0, 21'd0));
  endtask

  // Instruction set model that records every store
  task automatic run_model();
    word_t rf [32];
    word_t mref [mem_words];
    word_t pc;
    word_t insn;
    word_t a;
    word_t b;
    word_t r;
    word_t ea;
    word_t next_pc;
    logic  wr;
    for (int i = 0; i < 32; i++) rf[i] = '0;
    for (int i = 0; i < mem_words; i++) mref[i] = fill_word(i);
    pc = reset_pc;
    for (int step = 0; step < 1000; step++) begin
      if (pc == halt_pc) break;
      insn    = imem[pc[7:2]];
      a       = rf[insn[19:15]];
      b       = rf[insn[24:20]];
      r       = '0;
      wr      = 1'b1;
      next_pc = pc + 32'd4;
      case (insn[6:0])
        opc_lui:    r = {insn[31:12], 12'b0};
        opc_op_imm: r = alu_result(insn[14:12], 1'b0, a, 32'($signed(insn[31:20])));
        opc_op:     r = alu_result(insn[14:12], insn[30], a, b);
        opc_load: begin
          ea = a + 32'($signed(insn[31:20]));
          r  = mref[ea[7:2]];
        end
        opc_store: begin
          ea            = a + 32'($signed({insn[31:25], insn[11:7]}));
          mref[ea[7:2]] = b;
          wr            = 1'b0;
          exp_addr.push_back(ea);
          exp_data.push_back(b);
        end
        opc_branch: begin
          wr = 1'b0;
          if ((a == b) == (insn[14:12] == f3_beq)) begin
            next_pc = pc + 32'($signed({insn[31], insn[7], insn[30:25], insn[11:8], 1'b0}));
          end
        end
        opc_jal: begin
          r       = pc + 32'd4;
          next_pc = pc + 32'($signed({insn[31], insn[19:12], insn[20], insn[30:21], 1'b0}));
        end
        default: wr = 1'b0;
      endcase
      if (wr && insn[11:7] != 5'd0) rf[insn[11:7]] = r;
      pc = next_pc;
    end
  endtask

  task automatic check_store(word_t addr, word_t data);
    if (exp_addr.size() == 0) begin
      $display("ERROR at %0t: store of %h to %h that the model never makes", $time, data, addr);
      other_errors++;
    end else begin
      if (addr !== exp_addr[0]) begin
        $display("MISMATCH at %0t: o_membus_addr = %h, expected %h", $time, addr, exp_addr[0]);
        mismatches++;
      end
      if (data !== exp_data[0]) begin
        $display("MISMATCH at %0t: o_membus_data = %h, expected %h", $time, data, exp_data[0]);
        mismatches++;
      end
      void'(exp_addr.pop_front());
      void'(exp_data.pop_front());
      stores_checked++;
    end
  endtask

  // Both bus slaves in one process so the random stream has a fixed order
  always @(posedge clk) begin
    if (!i_arst_n) begin
      i_instbus_ack <= 1'b0;
      i_membus_ack  <= 1'b0;
      ibus_busy = 1'b0;
      dbus_busy = 1'b0;
    end else begin
      if (i_instbus_ack) begin
        i_instbus_ack <= 1'b0;
        ibus_busy = 1'b0;
      end else if (o_instbus_req) begin
        if (!ibus_busy) begin
          ibus_busy = 1'b1;
          ibus_wait = int'(random_bits() % 4);
        end
        if (ibus_wait == 0) begin
          i_instbus_ack  <= 1'b1;
          i_instbus_data <= imem[o_instbus_addr[7:2]];
          if (o_instbus_addr == halt_pc) halt_hits++;
        end else begin
          ibus_wait--;
        end
      end
      if (i_membus_ack) begin
        i_membus_ack <= 1'b0;
        dbus_busy = 1'b0;
      end else if (o_membus_req) begin
        if (!dbus_busy) begin
          dbus_busy = 1'b1;
          dbus_wait = int'(random_bits() % 4);
        end
        if (dbus_wait == 0) begin
          i_membus_ack <= 1'b1;
          if (o_membus_write) begin
            dmem[o_membus_addr[7:2]] = o_membus_data;
            check_store(o_membus_addr, o_membus_data);
          end else begin
            i_membus_data <= dmem[o_membus_addr[7:2]];
          end
        end else begin
          dbus_wait--;
        end
      end
    end
  end

  initial begin
    i_arst_n       = 1'b0;
    i_instbus_ack  = 1'b0;
    i_instbus_data = '0;
    i_membus_ack   = 1'b0;
    i_membus_data  = '0;
    ibus_busy      = 1'b0;
    dbus_busy      = 1'b0;
    ibus_wait      = 0;
    dbus_wait      = 0;
    halt_hits      = 0;
    mismatches     = 0;
    other_errors   = 0;
    assert_errors  = 0;
    stores_checked = 0;
    seed           = 32'd22;
    build_program();
    run_model();
    repeat (5) @(posedge clk);
    i_arst_n <= 1'b1;
    cycles = 0;
    while (exp_addr.size() > 0 && cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_addr.size() > 0) begin
      $display("ERROR: timed out with %0d expected stores still missing", exp_addr.size());
      other_errors++;
    end
    // Let the core spin in its final loop so a stray store would still show up
    hits_start = halt_hits;
    cycles     = 0;
    while (halt_hits < hits_start + 4 && cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    if (halt_hits < hits_start + 4) begin
      $display("ERROR: timed out waiting for the core to reach its final loop");
      other_errors++;
    end
    $display("Errors: %0d mismatches, %0d other, %0d assertion failures, %0d stores checked",
             mismatches, other_errors, assert_errors, stores_checked);
    if (mismatches == 0 && other_errors == 0 && assert_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
hw/rv_isa_pkg.sv
hw/rv_pipe_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_core.sv
testbench/rv_core_assert.sv
testbench/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

dependencies: {}

sources:
  - files:
      - hw/rv_isa_pkg.sv
      - hw/rv_pipe_pkg.sv
      - hw/rv_fetch.sv
      - hw/rv_decode.sv
      - hw/rv_regfile.sv
      - hw/rv_execute.sv
      - hw/rv_core.sv
  - target: simulation
    files:
      - testbench/rv_core_assert.sv
      - testbench/tb_rv_core.sv
